// File: common/neo_pkg.sv
`default_nettype none

package neo_pkg;

	localparam int BANK3_AW     = 24;
	localparam int CART_AW      = 26;
	localparam int SAMPLE_W     = 64;
	localparam int HEADER_BYTES = 4096;

	// Regions in the order they follow the header
	typedef enum logic [2:0] {
		REG_P    = 3'd0,
		REG_S    = 3'd1,
		REG_M    = 3'd2,
		REG_V1   = 3'd3,
		REG_V2   = 3'd4,
		REG_C    = 3'd5,
		REG_DONE = 3'd6
	} region_e;

	// P sits in the low word, as the sizes arrive first byte first
	typedef struct packed {
		logic [31:0] c_size;
		logic [31:0] v2_size;
		logic [31:0] v1_size;
		logic [31:0] m_size;
		logic [31:0] s_size;
		logic [31:0] p_size;
	} rom_layout_t;

	typedef logic [7:0] byte_in_t;

	typedef struct packed {
		logic [BANK3_AW-1:0] addr;
		logic [7:0]          data;
	} bank3_wr_t;

	typedef struct packed {
		logic [CART_AW-1:0] addr;
		logic [7:0]         data;
	} cart_wr_t;

	typedef logic [23:0]        sample_req_t;
	typedef logic [CART_AW-4:0] cart_rd_t;    // 64-bit word address
	typedef logic [7:0]         sample_rsp_t;

endpackage

`default_nettype wire

// File: loader/neo_header_parser.sv
`default_nettype none
`timescale 1ns/1ps

module neo_header_parser #(
	parameter int HEADER_BYTES = 4096
) (
	input  wire                         CLK_24M,
	input  wire                         rst_n,
	input  neo_pkg::byte_in_t           in_byte,
	input  wire                         in_valid,
	input  wire                         in_ready,
	output logic                        header_done,
	output logic [neo_pkg::CART_AW-1:0] file_addr,
	output neo_pkg::rom_layout_t        layout
);

	logic take;
	logic size_byte;
	logic last_hdr_byte;

	assign take = in_valid && in_ready;

	// Bytes 4..27 hold the six little-endian sizes
	assign size_byte = !header_done &&
		(file_addr >= neo_pkg::CART_AW'(4)) && (file_addr < neo_pkg::CART_AW'(28));

	assign last_hdr_byte = !header_done &&
		(file_addr == neo_pkg::CART_AW'(HEADER_BYTES - 1));

	always_ff @(posedge CLK_24M or negedge rst_n) begin
		if (!rst_n) begin
			file_addr   <= '0;
			header_done <= 1'b0;
		end else if (take) begin
			file_addr <= file_addr + 1'b1;
			if (last_hdr_byte)
				header_done <= 1'b1;
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (take && size_byte)
			layout <= {in_byte, layout[$bits(neo_pkg::rom_layout_t)-1:8]};

		// Merged ADPCM files give no V2, so V1 is shared half and half
		if (take && last_hdr_byte && layout.v2_size == 32'd0) begin
			layout.v1_size <= layout.v1_size >> 1;
			layout.v2_size <= layout.v1_size >> 1;
		end
	end

endmodule

`default_nettype wire

// File: loader/neo_region_writer.sv
`default_nettype none
`timescale 1ns/1ps

module neo_region_writer (
	input  wire                         CLK_24M,
	input  wire                         rst_n,
	input  neo_pkg::byte_in_t           in_byte,
	input  wire                         in_valid,
	output logic                        in_ready,
	input  wire                         header_done,
	input  wire  [neo_pkg::CART_AW-1:0] file_addr,
	input  neo_pkg::rom_layout_t        layout,
	output neo_pkg::bank3_wr_t          b3_wr,
	output logic                        b3_wr_valid,
	input  wire                         b3_wr_ready,
	output neo_pkg::cart_wr_t           cart_wr,
	output logic                        cart_wr_valid,
	input  wire                         cart_wr_ready,
	output logic                        load_done
);

	typedef enum logic [2:0] {
		ST_INIT, ST_HEADER, ST_IDLE, ST_WRITE, ST_NEXT, ST_DONE
	} state_t;

	state_t                       state;
	neo_pkg::region_e             region;
	logic [neo_pkg::CART_AW-1:0]  offset;
	logic [neo_pkg::CART_AW-1:0]  region_size;
	logic [neo_pkg::CART_AW-1:0]  next_offset;
	logic [neo_pkg::BANK3_AW-1:0] b3_addr;
	logic [neo_pkg::CART_AW-1:0]  cart_addr;
	logic                         accept;
	logic                         wr_done;
	logic                         to_bank3;

	assign in_ready    = (state == ST_IDLE) || (state == ST_HEADER && !header_done);
	assign load_done   = (state == ST_DONE);
	assign accept      = (state == ST_IDLE) && in_valid;
	assign wr_done     = (b3_wr_valid && b3_wr_ready) || (cart_wr_valid && cart_wr_ready);
	assign to_bank3    = (region <= neo_pkg::REG_M);
	assign next_offset = offset + 1'b1;

	always_comb begin
		case (region)
			neo_pkg::REG_P:  region_size = layout.p_size[neo_pkg::CART_AW-1:0];
			neo_pkg::REG_S:  region_size = layout.s_size[neo_pkg::CART_AW-1:0];
			neo_pkg::REG_M:  region_size = layout.m_size[neo_pkg::CART_AW-1:0];
			neo_pkg::REG_V1: region_size = layout.v1_size[neo_pkg::CART_AW-1:0];
			neo_pkg::REG_V2: region_size = layout.v2_size[neo_pkg::CART_AW-1:0];
			neo_pkg::REG_C:  region_size = layout.c_size[neo_pkg::CART_AW-1:0];
			default:         region_size = '0;
		endcase
	end

	always_comb begin
		case (region)
			neo_pkg::REG_S: b3_addr = {5'b11100, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			neo_pkg::REG_M: b3_addr = {5'b11110, offset[18:0]};
			default:        b3_addr = offset[neo_pkg::BANK3_AW-1:0];
		endcase
	end

	// V1 and V2 sit above the sprite data in the cart space
	always_comb begin
		case (region)
			neo_pkg::REG_V1: cart_addr = layout.c_size[neo_pkg::CART_AW-1:0] + offset;
			neo_pkg::REG_V2: cart_addr = layout.c_size[neo_pkg::CART_AW-1:0] +
				layout.v1_size[neo_pkg::CART_AW-1:0] + offset;
			default: cart_addr = {offset[25:7], file_addr[5:2], ~file_addr[6],
				file_addr[0], file_addr[1]};
		endcase
	end

	always_ff @(posedge CLK_24M or negedge rst_n) begin
		if (!rst_n) begin
			state         <= ST_INIT;
			region        <= neo_pkg::REG_P;
			offset        <= '0;
			b3_wr_valid   <= 1'b0;
			cart_wr_valid <= 1'b0;
		end else begin
			case (state)
				ST_INIT: state <= ST_HEADER;
				ST_HEADER, ST_NEXT: if (state == ST_NEXT || header_done) begin
					if (region == neo_pkg::REG_DONE)
						state <= ST_DONE;
					else if (region_size == '0)
						region <= neo_pkg::region_e'(region + 3'd1); // Empty region
					else
						state <= ST_IDLE;
				end
				ST_IDLE: if (accept) begin
					state         <= ST_WRITE;
					b3_wr_valid   <= to_bank3;
					cart_wr_valid <= !to_bank3;
				end
				ST_WRITE: if (wr_done) begin
					b3_wr_valid   <= 1'b0;
					cart_wr_valid <= 1'b0;
					if (next_offset == region_size) begin
						offset <= '0;
						region <= neo_pkg::region_e'(region + 3'd1);
						state  <= ST_NEXT;
					end else begin
						offset <= next_offset;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_DONE;
			endcase
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (accept) begin
			b3_wr.addr   <= b3_addr;
			b3_wr.data   <= in_byte;
			cart_wr.addr <= cart_addr;
			cart_wr.data <= in_byte;
		end
	end

endmodule

`default_nettype wire

// File: sample/adpcm_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module adpcm_fetch #(
	parameter bit CHANNEL_B = 1'b0
) (
	input  wire                          CLK_24M,
	input  wire                          rst_n,
	input  neo_pkg::rom_layout_t         layout,
	input  wire                          load_done,
	input  neo_pkg::sample_req_t         req,
	input  wire                          req_valid,
	output logic                         req_ready,
	output neo_pkg::sample_rsp_t         rsp,
	output logic                         rsp_valid,
	output neo_pkg::cart_rd_t            rd,
	output logic                         rd_valid,
	input  wire                          rd_ready,
	input  wire  [neo_pkg::SAMPLE_W-1:0] rd_data,
	input  wire                          rd_data_valid
);

	logic [31:0]                 chan_size;
	logic [31:0]                 chan_mask;
	logic [31:0]                 chan_base;
	logic [neo_pkg::CART_AW-1:0] byte_addr;
	neo_pkg::cart_rd_t           word_addr;
	neo_pkg::cart_rd_t           cache_tag;
	logic [neo_pkg::SAMPLE_W-1:0] cache_data;
	logic                        cache_valid;
	logic [2:0]                  byte_sel;
	logic                        busy;
	logic                        hit;
	logic                        accept;

	// A uses V1, B uses V2 stacked right after it
	assign chan_size = CHANNEL_B ? layout.v2_size : layout.v1_size;
	assign chan_mask = chan_size - 32'd1;
	assign chan_base = CHANNEL_B ? layout.c_size + layout.v1_size : layout.c_size;

	assign byte_addr = chan_base[neo_pkg::CART_AW-1:0] +
		neo_pkg::CART_AW'(req & chan_mask[23:0]);
	assign word_addr = byte_addr[neo_pkg::CART_AW-1:3];
	assign hit       = cache_valid && (word_addr == cache_tag);

	assign req_ready = load_done && !busy;
	assign accept    = req_valid && req_ready;
	assign rd        = cache_tag;

	always_ff @(posedge CLK_24M or negedge rst_n) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			cache_valid <= 1'b0;
			rd_valid    <= 1'b0;
			rsp_valid   <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (accept) begin
				if (hit) begin
					rsp_valid <= 1'b1;
				end else begin
					busy        <= 1'b1;
					cache_valid <= 1'b0;
					rd_valid    <= 1'b1;
				end
			end
			if (rd_valid && rd_ready)
				rd_valid <= 1'b0;
			if (rd_data_valid && busy) begin
				busy        <= 1'b0;
				cache_valid <= 1'b1;
				rsp_valid   <= 1'b1;
			end
		end
	end

	// Byte 0 is the least significant byte of the word
	always_ff @(posedge CLK_24M) begin
		if (accept) begin
			byte_sel <= byte_addr[2:0];
			rsp      <= cache_data[{byte_addr[2:0], 3'b000} +: 8];
			if (!hit)
				cache_tag <= word_addr;
		end
		if (rd_data_valid && busy) begin
			cache_data <= rd_data;
			rsp        <= rd_data[{byte_sel, 3'b000} +: 8];
		end
	end

endmodule

`default_nettype wire

// File: source/sample_read_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module sample_read_arbiter (
	input  wire               CLK_24M,
	input  wire               rst_n,
	input  neo_pkg::cart_rd_t rd_a,
	input  wire               rd_a_valid,
	output logic              rd_a_ready,
	input  neo_pkg::cart_rd_t rd_b,
	input  wire               rd_b_valid,
	output logic              rd_b_ready,
	output logic              rd_data_a_valid,
	output logic              rd_data_b_valid,
	output neo_pkg::cart_rd_t mem_rd,
	output logic              mem_rd_valid,
	input  wire               mem_rd_ready,
	input  wire               mem_rd_data_valid
);

	logic busy;     // Channel granted, read not yet returned
	logic issued;   // Read taken by the memory
	logic owner_b;  // Granted channel, kept as the last one after release
	logic pick_b;
	logic owner_valid;

	// Alternate when both channels ask at once
	assign pick_b      = rd_b_valid && (!rd_a_valid || !owner_b);
	assign owner_valid = owner_b ? rd_b_valid : rd_a_valid;

	assign mem_rd       = owner_b ? rd_b : rd_a;
	assign mem_rd_valid = busy && !issued && owner_valid;
	assign rd_a_ready   = busy && !issued && !owner_b && mem_rd_ready;
	assign rd_b_ready   = busy && !issued && owner_b && mem_rd_ready;

	assign rd_data_a_valid = mem_rd_data_valid && issued && !owner_b;
	assign rd_data_b_valid = mem_rd_data_valid && issued && owner_b;

	always_ff @(posedge CLK_24M or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			issued  <= 1'b0;
			owner_b <= 1'b0;
		end else if (!busy) begin
			if (rd_a_valid || rd_b_valid) begin
				busy    <= 1'b1;
				owner_b <= pick_b;
			end
		end else if (!issued) begin
			if (mem_rd_valid && mem_rd_ready)
				issued <= 1'b1;
		end else if (mem_rd_data_valid) begin
			busy   <= 1'b0;
			issued <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/neo_rom_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module neo_rom_ctrl #(
	parameter int HEADER_BYTES = neo_pkg::HEADER_BYTES
) (
	input  wire                          CLK_24M,
	input  wire                          rst_n,
	input  neo_pkg::byte_in_t            in_byte,
	input  wire                          in_valid,
	output logic                         in_ready,
	output neo_pkg::bank3_wr_t           b3_wr,
	output logic                         b3_wr_valid,
	input  wire                          b3_wr_ready,
	output neo_pkg::cart_wr_t            cart_wr,
	output logic                         cart_wr_valid,
	input  wire                          cart_wr_ready,
	output logic                         load_done,
	input  neo_pkg::sample_req_t         adpcma_req,
	input  wire                          adpcma_req_valid,
	output logic                         adpcma_req_ready,
	output neo_pkg::sample_rsp_t         adpcma_rsp,
	output logic                         adpcma_rsp_valid,
	input  neo_pkg::sample_req_t         adpcmb_req,
	input  wire                          adpcmb_req_valid,
	output logic                         adpcmb_req_ready,
	output neo_pkg::sample_rsp_t         adpcmb_rsp,
	output logic                         adpcmb_rsp_valid,
	output neo_pkg::cart_rd_t            rd_addr,
	output logic                         rd_valid,
	input  wire                          rd_ready,
	input  wire  [neo_pkg::SAMPLE_W-1:0] rd_data,
	input  wire                          rd_data_valid
);

	logic                        header_done;
	logic [neo_pkg::CART_AW-1:0] file_addr;
	neo_pkg::rom_layout_t        layout;
	neo_pkg::cart_rd_t           rd_a;
	neo_pkg::cart_rd_t           rd_b;
	logic                        rd_a_valid;
	logic                        rd_a_ready;
	logic                        rd_b_valid;
	logic                        rd_b_ready;
	logic                        rd_data_a_valid;
	logic                        rd_data_b_valid;

	neo_header_parser #(.HEADER_BYTES(HEADER_BYTES)) u_parser (
		.CLK_24M     (CLK_24M),
		.rst_n       (rst_n),
		.in_byte     (in_byte),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.header_done (header_done),
		.file_addr   (file_addr),
		.layout      (layout)
	);

	neo_region_writer u_writer (
		.CLK_24M       (CLK_24M),
		.rst_n         (rst_n),
		.in_byte       (in_byte),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.header_done   (header_done),
		.file_addr     (file_addr),
		.layout        (layout),
		.b3_wr         (b3_wr),
		.b3_wr_valid   (b3_wr_valid),
		.b3_wr_ready   (b3_wr_ready),
		.cart_wr       (cart_wr),
		.cart_wr_valid (cart_wr_valid),
		.cart_wr_ready (cart_wr_ready),
		.load_done     (load_done)
	);

	adpcm_fetch #(.CHANNEL_B(1'b0)) u_fetch_a (
		.CLK_24M       (CLK_24M),
		.rst_n         (rst_n),
		.layout        (layout),
		.load_done     (load_done),
		.req           (adpcma_req),
		.req_valid     (adpcma_req_valid),
		.req_ready     (adpcma_req_ready),
		.rsp           (adpcma_rsp),
		.rsp_valid     (adpcma_rsp_valid),
		.rd            (rd_a),
		.rd_valid      (rd_a_valid),
		.rd_ready      (rd_a_ready),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_a_valid)
	);

	adpcm_fetch #(.CHANNEL_B(1'b1)) u_fetch_b (
		.CLK_24M       (CLK_24M),
		.rst_n         (rst_n),
		.layout        (layout),
		.load_done     (load_done),
		.req           (adpcmb_req),
		.req_valid     (adpcmb_req_valid),
		.req_ready     (adpcmb_req_ready),
		.rsp           (adpcmb_rsp),
		.rsp_valid     (adpcmb_rsp_valid),
		.rd            (rd_b),
		.rd_valid      (rd_b_valid),
		.rd_ready      (rd_b_ready),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_b_valid)
	);

	sample_read_arbiter u_arbiter (
		.CLK_24M           (CLK_24M),
		.rst_n             (rst_n),
		.rd_a              (rd_a),
		.rd_a_valid        (rd_a_valid),
		.rd_a_ready        (rd_a_ready),
		.rd_b              (rd_b),
		.rd_b_valid        (rd_b_valid),
		.rd_b_ready        (rd_b_ready),
		.rd_data_a_valid   (rd_data_a_valid),
		.rd_data_b_valid   (rd_data_b_valid),
		.mem_rd            (rd_addr),
		.mem_rd_valid      (rd_valid),
		.mem_rd_ready      (rd_ready),
		.mem_rd_data_valid (rd_data_valid)
	);

endmodule

`default_nettype wire

// File: verif/neo_rom_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module neo_rom_ctrl_sva (
	input wire                CLK_24M,
	input wire                rst_n,
	input wire                in_ready,
	input neo_pkg::bank3_wr_t b3_wr,
	input wire                b3_wr_valid,
	input wire                b3_wr_ready,
	input neo_pkg::cart_wr_t  cart_wr,
	input wire                cart_wr_valid,
	input wire                cart_wr_ready,
	input neo_pkg::cart_rd_t  rd_addr,
	input wire                rd_valid,
	input wire                rd_ready,
	input wire                rd_data_valid
);

	logic rd_out; // Read accepted, data not back yet

	always_ff @(posedge CLK_24M or negedge rst_n) begin
		if (!rst_n)
			rd_out <= 1'b0;
		else if (rd_valid && rd_ready)
			rd_out <= 1'b1;
		else if (rd_data_valid)
			rd_out <= 1'b0;
	end

	b3_hold: assert property (@(posedge CLK_24M) disable iff (!rst_n)
		b3_wr_valid && !b3_wr_ready |=> b3_wr_valid && $stable(b3_wr))
		else $error("bank3 write changed before ready");

	cart_hold: assert property (@(posedge CLK_24M) disable iff (!rst_n)
		cart_wr_valid && !cart_wr_ready |=> cart_wr_valid && $stable(cart_wr))
		else $error("cart write changed before ready");

	rd_hold: assert property (@(posedge CLK_24M) disable iff (!rst_n)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
		else $error("cart read changed before ready");

	no_in_during_wr: assert property (@(posedge CLK_24M) disable iff (!rst_n)
		(b3_wr_valid || cart_wr_valid) |-> !in_ready)
		else $error("in_ready high while a write is pending");

	one_read: assert property (@(posedge CLK_24M) disable iff (!rst_n)
		rd_out |-> !rd_valid)
		else $error("second cart read while one is outstanding");

endmodule

bind neo_rom_ctrl neo_rom_ctrl_sva u_sva (
	.CLK_24M       (CLK_24M),
	.rst_n         (rst_n),
	.in_ready      (in_ready),
	.b3_wr         (b3_wr),
	.b3_wr_valid   (b3_wr_valid),
	.b3_wr_ready   (b3_wr_ready),
	.cart_wr       (cart_wr),
	.cart_wr_valid (cart_wr_valid),
	.cart_wr_ready (cart_wr_ready),
	.rd_addr       (rd_addr),
	.rd_valid      (rd_valid),
	.rd_ready      (rd_ready),
	.rd_data_valid (rd_data_valid)
);

`default_nettype wire

// File: verif/tb_neo_rom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_neo_rom_ctrl;

	localparam int HDR       = neo_pkg::HEADER_BYTES;
	localparam int PAT_WORDS = 69;

	logic                 CLK_24M;
	logic                 rst_n;
	neo_pkg::byte_in_t    in_byte;
	logic                 in_valid;
	logic                 in_ready;
	neo_pkg::bank3_wr_t   b3_wr;
	logic                 b3_wr_valid;
	logic                 b3_wr_ready;
	neo_pkg::cart_wr_t    cart_wr;
	logic                 cart_wr_valid;
	logic                 cart_wr_ready;
	logic                 load_done;
	neo_pkg::sample_req_t adpcma_req;
	logic                 adpcma_req_valid;
	logic                 adpcma_req_ready;
	neo_pkg::sample_rsp_t adpcma_rsp;
	logic                 adpcma_rsp_valid;
	neo_pkg::sample_req_t adpcmb_req;
	logic                 adpcmb_req_valid;
	logic                 adpcmb_req_ready;
	neo_pkg::sample_rsp_t adpcmb_rsp;
	logic                 adpcmb_rsp_valid;
	neo_pkg::cart_rd_t    rd_addr;
	logic                 rd_valid;
	logic                 rd_ready;
	logic [63:0]          rd_data;
	logic                 rd_data_valid;

	logic [31:0]        pat [0:PAT_WORDS-1];
	logic [15:0]        lfsr;
	int                 cycle = 0;
	int                 cycle_limit = 0;
	int                 errors = 0;
	int                 checks = 0;
	int                 tests = 0;
	int                 tests_failed = 0;
	int                 rd_count = 0;
	neo_pkg::byte_in_t  file_q [$];
	neo_pkg::bank3_wr_t exp_b3 [$];
	neo_pkg::cart_wr_t  exp_cart [$];
	logic [7:0]         exp_mem [int];
	logic [7:0]         cart_mem [int];

	neo_rom_ctrl #(.HEADER_BYTES(HDR)) DUT (.*);

	initial CLK_24M = 1'b0;
	always #50 CLK_24M = ~CLK_24M;

	always @(posedge CLK_24M) begin
		cycle++;
		if (cycle_limit > 0 && cycle > cycle_limit) begin
			$display("Timeout: run went past %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic check_bank3_wr(input neo_pkg::bank3_wr_t got, input neo_pkg::bank3_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: bank3 write %h/%h, expected %h/%h",
				$time, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic check_cart_wr(input neo_pkg::cart_wr_t got, input neo_pkg::cart_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: cart write %h/%h, expected %h/%h",
				$time, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic check_sample(input neo_pkg::sample_rsp_t got, input neo_pkg::sample_rsp_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s byte %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Memory model and write sink, all on the falling edge
	task automatic mem_step(inout logic busy, inout int wait_n, inout neo_pkg::cart_rd_t word);
		logic [7:0]  r;
		logic [63:0] w;
		int          a;
		take_bits(2, r);
		b3_wr_ready = (r[1:0] != 2'b00);
		take_bits(2, r);
		cart_wr_ready = (r[1:0] != 2'b00);
		if (b3_wr_valid && b3_wr_ready) begin
			if (exp_b3.size() == 0) begin
				errors++;
				$display("Unexpected bank3 write at %0t to %h", $time, b3_wr.addr);
			end else
				check_bank3_wr(b3_wr, exp_b3.pop_front());
		end
		if (cart_wr_valid && cart_wr_ready) begin
			cart_mem[int'(cart_wr.addr)] = cart_wr.data;
			if (exp_cart.size() == 0) begin
				errors++;
				$display("Unexpected cart write at %0t to %h", $time, cart_wr.addr);
			end else
				check_cart_wr(cart_wr, exp_cart.pop_front());
		end
		rd_data_valid = 1'b0;
		if (busy) begin
			wait_n--;
			if (wait_n == 0) begin
				for (int i = 0; i < 8; i++) begin
					a = int'(word) * 8 + i;
					w[i*8 +: 8] = cart_mem.exists(a) ? cart_mem[a] : 8'h00;
				end
				rd_data       = w;
				rd_data_valid = 1'b1;
				busy          = 1'b0;
			end
		end
		rd_ready = !busy;
		if (rd_valid && rd_ready) begin
			take_bits(2, r);
			busy   = 1'b1;
			word   = rd_addr;
			wait_n = int'(r[1:0]) + 1;
			rd_count++;
		end
	endtask

	initial begin : mem_model
		logic              busy;
		int                wait_n;
		neo_pkg::cart_rd_t word;
		busy          = 1'b0;
		wait_n        = 0;
		word          = '0;
		b3_wr_ready   = 1'b0;
		cart_wr_ready = 1'b0;
		rd_ready      = 1'b0;
		rd_data       = '0;
		rd_data_valid = 1'b0;
		forever begin
			@(negedge CLK_24M);
			mem_step(busy, wait_n, word);
		end
	end

	// Header from the sizes, then LFSR data with the expected write for each byte
	task automatic build_file(input int first);
		logic [31:0]        sz [0:5];
		logic [31:0]        eff [0:5];
		logic [7:0]         d;
		logic [25:0]        off;
		logic [25:0]        f;
		neo_pkg::bank3_wr_t bw;
		neo_pkg::cart_wr_t  cw;
		file_q.delete();
		exp_b3.delete();
		exp_cart.delete();
		exp_mem.delete();
		bw = '0;
		cw = '0;
		for (int r = 0; r < 6; r++) begin
			sz[r]  = pat[first + r];
			eff[r] = sz[r];
		end
		if (sz[4] == 0) begin
			eff[3] = sz[3] >> 1;
			eff[4] = sz[3] >> 1;
		end
		for (int i = 0; i < HDR; i++)
			file_q.push_back(8'h00);
		for (int r = 0; r < 6; r++)
			for (int b = 0; b < 4; b++)
				file_q[4 + r * 4 + b] = sz[r][b*8 +: 8];
		for (int r = 0; r < 6; r++) begin
			for (int o = 0; o < int'(eff[r]); o++) begin
				take_bits(8, d);
				off = 26'(o);
				f   = 26'(file_q.size());
				case (r)
					0: bw.addr = off[23:0];
					1: bw.addr = 24'hE00000 + {5'b0, off[18:5], off[2:0], ~off[4], off[3]};
					2: bw.addr = 24'hF00000 + {5'b0, off[18:0]};
					3: cw.addr = eff[5][25:0] + off;
					4: cw.addr = eff[5][25:0] + eff[3][25:0] + off;
					default: cw.addr = {off[25:7], f[5:2], ~f[6], f[0], f[1]};
				endcase
				if (r < 3) begin
					bw.data = d;
					exp_b3.push_back(bw);
				end else begin
					cw.data = d;
					exp_cart.push_back(cw);
					exp_mem[int'(cw.addr)] = d;
				end
				file_q.push_back(d);
			end
		end
	endtask

	task automatic apply_reset(input int first);
		@(negedge CLK_24M);
		rst_n            = 1'b0;
		in_valid         = 1'b0;
		adpcma_req_valid = 1'b0;
		adpcmb_req_valid = 1'b0;
		repeat (5) @(posedge CLK_24M);
		build_file(first);
		@(negedge CLK_24M);
		rst_n = 1'b1;
	endtask

	task automatic send_file();
		int   idx;
		logic armed;
		idx   = 0;
		armed = 1'b0;
		while (idx < file_q.size()) begin
			@(negedge CLK_24M);
			if (armed)
				idx++;
			if (idx < file_q.size()) begin
				in_valid = 1'b1;
				in_byte  = file_q[idx];
				armed    = in_ready;
			end else begin
				in_valid = 1'b0;
				armed    = 1'b0;
			end
		end
	endtask

	task automatic end_test(input string name, input int e0);
		tests++;
		if (errors > e0) begin
			tests_failed++;
			$display("%s: FAIL (%0d errors)", name, errors - e0);
		end else
			$display("%s: PASS", name);
	endtask

	task automatic run_load(input int first, input string name);
		int e0;
		int n;
		e0 = errors;
		apply_reset(first);
		send_file();
		n = 0;
		while (!load_done && n < 50) begin
			@(negedge CLK_24M);
			n++;
		end
		if (!load_done) begin
			errors++;
			$display("load_done did not rise after the last file byte");
		end
		if (exp_b3.size() != 0 || exp_cart.size() != 0) begin
			errors++;
			$display("%0d bank3 and %0d cart writes never came", exp_b3.size(), exp_cart.size());
		end
		end_test(name, e0);
	endtask

	task automatic read_pair(input logic use_a, input logic use_b,
		input neo_pkg::sample_req_t ra, input neo_pkg::sample_req_t rb,
		input int ma, input int mb);
		logic arm_a;
		logic arm_b;
		logic got_a;
		logic got_b;
		int   n;
		got_a = !use_a;
		got_b = !use_b;
		arm_a = 1'b0;
		arm_b = 1'b0;
		@(negedge CLK_24M);
		if (use_a) begin
			adpcma_req       = ra;
			adpcma_req_valid = 1'b1;
			arm_a            = adpcma_req_ready;
		end
		if (use_b) begin
			adpcmb_req       = rb;
			adpcmb_req_valid = 1'b1;
			arm_b            = adpcmb_req_ready;
		end
		n = 0;
		while (!(got_a && got_b) && n < 40) begin
			@(negedge CLK_24M);
			n++;
			if (arm_a) begin
				adpcma_req_valid = 1'b0;
				arm_a            = 1'b0;
			end else if (adpcma_req_valid)
				arm_a = adpcma_req_ready;
			if (arm_b) begin
				adpcmb_req_valid = 1'b0;
				arm_b            = 1'b0;
			end else if (adpcmb_req_valid)
				arm_b = adpcmb_req_ready;
			if (adpcma_rsp_valid) begin
				if (got_a || !exp_mem.exists(ma)) begin
					errors++;
					$display("ADPCM-A response at %0t with nothing expected", $time);
				end else
					check_sample(adpcma_rsp, exp_mem[ma], "ADPCM-A");
				got_a = 1'b1;
			end
			if (adpcmb_rsp_valid) begin
				if (got_b || !exp_mem.exists(mb)) begin
					errors++;
					$display("ADPCM-B response at %0t with nothing expected", $time);
				end else
					check_sample(adpcmb_rsp, exp_mem[mb], "ADPCM-B");
				got_b = 1'b1;
			end
		end
		if (!(got_a && got_b)) begin
			errors++;
			$display("Sample read got no response within 40 cycles");
		end
	endtask

	task automatic run_reads(input int p, input int load);
		int e0;
		int c0;
		int k;
		for (int i = 0; i < int'(pat[p]); i++) begin
			e0 = errors;
			k  = p + 1 + i * 5;
			case (pat[k])
				32'd0: read_pair(1'b1, 1'b0, pat[k+1][23:0], '0, int'(pat[k+2]), 0);
				32'd1: read_pair(1'b0, 1'b1, '0, pat[k+1][23:0], 0, int'(pat[k+2]));
				32'd2: read_pair(1'b1, 1'b1, pat[k+1][23:0], pat[k+3][23:0],
					int'(pat[k+2]), int'(pat[k+4]));
				default: begin
					c0 = rd_count;
					read_pair(1'b1, 1'b0, pat[k+1][23:0], '0, int'(pat[k+2]), 0);
					read_pair(1'b1, 1'b0, pat[k+3][23:0], '0, int'(pat[k+4]), 0);
					check_count(rd_count - c0, 1, "cart reads for one word");
				end
			endcase
			end_test($sformatf("load %0d read %0d kind %0d", load, i, pat[k]), e0);
		end
	endtask

	initial begin : main
		int p2;
		int total;
		rst_n            = 1'b0;
		in_byte          = '0;
		in_valid         = 1'b0;
		adpcma_req       = '0;
		adpcma_req_valid = 1'b0;
		adpcmb_req       = '0;
		adpcmb_req_valid = 1'b0;
		lfsr             = 16'd92;
		$readmemh("verif/neo_patterns.hex", pat);
		p2    = 13 + 5 * int'(pat[12]);
		total = 2 * HDR + 10 + 20 * 2 * (int'(pat[12]) + int'(pat[p2]));
		for (int i = 0; i < 12; i++)
			total += int'(pat[i]);
		cycle_limit = 2 * total;

		run_load(0, "load 1 all regions");
		run_reads(12, 1);
		run_load(6, "load 2 empty S and split V1");
		run_reads(p2, 2);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/neo_pkg.sv
loader/neo_header_parser.sv
loader/neo_region_writer.sv
sample/adpcm_fetch.sv
source/sample_read_arbiter.sv
source/neo_rom_ctrl.sv
verif/neo_rom_ctrl_sva.sv
verif/tb_neo_rom_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the ROM path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_neo_rom_ctrl \
	-Mdir obj_dir -o sim_neo_rom_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_neo_rom_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verif/neo_patterns.hex
// Words 0-5 and 6-11: region sizes P S M V1 V2 C of load 1 and load 2
// Then per load: read count, and per read: kind addr_a mapped_a addr_b mapped_b
// Kind 0 = channel A, 1 = channel B, 2 = both at once, 3 = two A reads in one word
00000100 00000080 00000080 00000100 00000080 00000100
00000080 00000000 00000080 00000200 00000000 00000080
// Load 1 reads, A base 100 mask FF, B base 200 mask 7F
00000006
00000000 00000010 00000110 00000000 00000000
00000000 00000305 00000105 00000000 00000000
00000001 000000F3 00000273 00000000 00000000
00000002 00000040 00000140 00000021 00000221
00000003 00000088 00000188 0000008C 0000018C
00000000 000000FF 000001FF 00000000 00000000
// Load 2 reads after the V1 split, A base 80 mask FF, B base 180 mask FF
00000005
00000000 00000000 00000080 00000000 00000000
00000001 00000000 00000180 00000000 00000000
00000001 00000456 000001D6 00000000 00000000
00000002 000000FF 0000017F 00000101 00000181
00000003 00000020 000000A0 00000027 000000A7
